/* src/xpdr_pkg.sv */
package xpdr_pkg;

    // timing, 25 MHz system clock
    localparam int CLK_PER_US = 25;

    typedef logic [6:0]  cycle_cnt_t;  // pulse and window counters
    typedef logic [4:0]  uf_t;
    typedef logic [23:0] icao_addr_t;
    typedef logic [31:0] uf_mask_t;    // one enable bit per UF value
    typedef logic [1:0]  cfg_sel_t;
    typedef logic [5:0]  bit_count_t;

    // 0.7 to 0.9 us, lower bound rounded up
    localparam cycle_cnt_t P1_WIDTH_MIN   = cycle_cnt_t'((CLK_PER_US * 7 + 9) / 10);
    localparam cycle_cnt_t P1_WIDTH_MAX   = cycle_cnt_t'((CLK_PER_US * 9) / 10);
    // 1.8 to 2.2 us, leading edge to leading edge
    localparam cycle_cnt_t P2_SPACING_MIN = cycle_cnt_t'((CLK_PER_US * 18) / 10);
    localparam cycle_cnt_t P2_SPACING_MAX = cycle_cnt_t'((CLK_PER_US * 22) / 10);
    localparam cycle_cnt_t SYNC_WINDOW    = cycle_cnt_t'(CLK_PER_US * 4);  // 4 us

    localparam bit_count_t SHORT_MSG_BITS = 6'd56;

    localparam icao_addr_t ALL_CALL_ADDRESS = 24'hff_ffff;
    localparam uf_t        UF_ALL_CALL      = 5'd11;

    // UF 4, 5, 11, 20 and 21 accepted out of reset
    localparam uf_mask_t UF_ENABLE_RESET = 32'h0030_0830;

    // register select codes
    localparam cfg_sel_t CFG_OWN_ADDR      = 2'd0;
    localparam cfg_sel_t CFG_ADDR_ASSIGNED = 2'd1;
    localparam cfg_sel_t CFG_UF_MASK       = 2'd2;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_SYNC,
        CAPTURE,
        DECIDE
    } xpdr_state_t;

endpackage

/* src/xpdr_config.sv */
`timescale 1ns/1ps

module xpdr_config (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cfg_write,
    input  xpdr_pkg::cfg_sel_t   cfg_sel,
    input  logic [31:0]          cfg_wdata,
    output xpdr_pkg::icao_addr_t own_address,
    output logic                 address_assigned,
    output xpdr_pkg::uf_mask_t   uf_enable
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            own_address      <= '0;
            address_assigned <= 1'b0;
            uf_enable        <= xpdr_pkg::UF_ENABLE_RESET;
        end else if (cfg_write) begin
            case (cfg_sel)
                xpdr_pkg::CFG_OWN_ADDR: begin
                    own_address <= cfg_wdata[23:0];  // low 24 bits
                end
                xpdr_pkg::CFG_ADDR_ASSIGNED: begin
                    address_assigned <= cfg_wdata[0];
                end
                xpdr_pkg::CFG_UF_MASK: begin
                    uf_enable <= cfg_wdata;
                end
                default: begin
                    own_address <= own_address;  // unmapped, write dropped
                end
            endcase
        end
    end

    // select 3 has no register behind it
    a_cfg_sel_valid: assert property (
        @(posedge clk) disable iff (reset)
        cfg_write |-> (cfg_sel != 2'd3)
    ) else $error("config write to unmapped select %0d", cfg_sel);

endmodule

/* src/pulse_qualifier.sv */
`timescale 1ns/1ps

module pulse_qualifier (
    input  logic clk,
    input  logic reset,
    input  logic video,
    output logic preamble_ok
);

    typedef enum logic [1:0] {
        Q_IDLE,
        Q_P1_HIGH,
        Q_P2_WAIT
    } pq_state_t;

    pq_state_t            state;
    logic                 video_q;
    xpdr_pkg::cycle_cnt_t width_cnt;  // P1 high time
    xpdr_pkg::cycle_cnt_t space_cnt;  // since P1 leading edge
    logic                 video_rise;

    assign video_rise = video && !video_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= Q_IDLE;
            video_q     <= 1'b0;
            width_cnt   <= '0;
            space_cnt   <= '0;
            preamble_ok <= 1'b0;
        end else begin
            video_q     <= video;
            preamble_ok <= 1'b0;
            case (state)
                Q_IDLE: begin
                    if (video_rise) begin  // P1 leading edge
                        state     <= Q_P1_HIGH;
                        width_cnt <= 7'd1;
                        space_cnt <= 7'd1;
                    end
                end
                Q_P1_HIGH: begin
                    space_cnt <= space_cnt + 7'd1;
                    if (video) begin
                        if (width_cnt == xpdr_pkg::P1_WIDTH_MAX) begin
                            state <= Q_IDLE;  // too wide
                        end else begin
                            width_cnt <= width_cnt + 7'd1;
                        end
                    end else if (width_cnt >= xpdr_pkg::P1_WIDTH_MIN) begin
                        state <= Q_P2_WAIT;
                    end else begin
                        state <= Q_IDLE;  // too narrow
                    end
                end
                Q_P2_WAIT: begin
                    space_cnt <= space_cnt + 7'd1;
                    if (video_rise) begin
                        // P2 edge ends the attempt either way
                        state       <= Q_IDLE;
                        preamble_ok <= (space_cnt >= xpdr_pkg::P2_SPACING_MIN) &&
                                       (space_cnt <= xpdr_pkg::P2_SPACING_MAX);
                    end else if (space_cnt >= xpdr_pkg::P2_SPACING_MAX) begin
                        state <= Q_IDLE;  // no P2 in time
                    end
                end
                default: begin
                    state <= Q_IDLE;
                end
            endcase
        end
    end

endmodule

/* src/uplink_capture.sv */
`timescale 1ns/1ps

module uplink_capture (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 capture_start,
    input  logic                 bit_valid,
    input  logic                 bit_data,
    output logic                 frame_done,
    output xpdr_pkg::uf_t        uf,
    output xpdr_pkg::icao_addr_t ap_field
);

    logic [55:0]          frame_sr;  // first bit ends up at msb
    xpdr_pkg::bit_count_t bit_cnt;
    logic                 active;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bit_cnt    <= '0;
            active     <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (capture_start) begin
                bit_cnt <= '0;
                active  <= 1'b1;
            end else if (active) begin
                if (bit_cnt == xpdr_pkg::SHORT_MSG_BITS) begin
                    active     <= 1'b0;  // frame complete
                    frame_done <= 1'b1;
                end else if (bit_valid) begin
                    bit_cnt <= bit_cnt + 6'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active && !capture_start && bit_valid &&
            bit_cnt != xpdr_pkg::SHORT_MSG_BITS) begin
            frame_sr <= {frame_sr[54:0], bit_data};
        end
        if (active && !capture_start && bit_cnt == xpdr_pkg::SHORT_MSG_BITS) begin
            uf       <= frame_sr[55:51];  // held until next frame
            ap_field <= frame_sr[23:0];
        end
    end

    a_bit_cnt_range: assert property (
        @(posedge clk) disable iff (reset)
        bit_cnt <= xpdr_pkg::SHORT_MSG_BITS
    ) else $error("bit counter past frame length: %0d", bit_cnt);

endmodule

/* src/interrogation_ctrl.sv */
`timescale 1ns/1ps

module interrogation_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 preamble_ok,
    input  logic                 sync_rev,
    input  logic                 frame_done,
    input  xpdr_pkg::uf_t        uf,
    input  xpdr_pkg::icao_addr_t ap_field,
    input  xpdr_pkg::icao_addr_t own_address,
    input  logic                 address_assigned,
    input  xpdr_pkg::uf_mask_t   uf_enable,
    output logic                 capture_start,
    output logic                 demod_enable,
    output logic                 atcrbs_suppressed,
    output logic                 reply,
    output logic                 recover
);

    xpdr_pkg::xpdr_state_t state;
    xpdr_pkg::cycle_cnt_t  sync_cnt;
    logic                  uf_ok;
    logic                  addr_ok;
    logic                  accept;

    // decision rule on the latched frame fields
    assign uf_ok   = uf_enable[uf];
    assign addr_ok = (address_assigned && (ap_field == own_address)) ||
                     ((uf == xpdr_pkg::UF_ALL_CALL) &&
                      (ap_field == xpdr_pkg::ALL_CALL_ADDRESS));
    assign accept  = uf_ok && addr_ok;

    // same cycle as the sync sample, so no bit is missed
    assign capture_start = (state == xpdr_pkg::WAIT_SYNC) && sync_rev;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state             <= xpdr_pkg::IDLE;
            sync_cnt          <= '0;
            demod_enable      <= 1'b0;
            atcrbs_suppressed <= 1'b0;
            reply             <= 1'b0;
            recover           <= 1'b0;
        end else begin
            case (state)
                xpdr_pkg::IDLE: begin
                    if (preamble_ok) begin
                        state             <= xpdr_pkg::WAIT_SYNC;
                        sync_cnt          <= '0;
                        demod_enable      <= 1'b1;
                        atcrbs_suppressed <= 1'b1;  // Mode S in progress
                    end
                end
                xpdr_pkg::WAIT_SYNC: begin
                    if (sync_rev) begin
                        state <= xpdr_pkg::CAPTURE;
                    end else if (sync_cnt == xpdr_pkg::SYNC_WINDOW - 7'd1) begin
                        state             <= xpdr_pkg::DECIDE;  // sync never came
                        recover           <= 1'b1;
                        demod_enable      <= 1'b0;
                        atcrbs_suppressed <= 1'b0;
                    end else begin
                        sync_cnt <= sync_cnt + 7'd1;
                    end
                end
                xpdr_pkg::CAPTURE: begin
                    if (frame_done) begin
                        state             <= xpdr_pkg::DECIDE;
                        reply             <= accept;
                        recover           <= !accept;
                        demod_enable      <= 1'b0;
                        atcrbs_suppressed <= 1'b0;
                    end
                end
                xpdr_pkg::DECIDE: begin
                    // outcome pulse lasts this one cycle
                    state   <= xpdr_pkg::IDLE;
                    reply   <= 1'b0;
                    recover <= 1'b0;
                end
                default: begin
                    state <= xpdr_pkg::IDLE;
                end
            endcase
        end
    end

    a_one_outcome: assert property (
        @(posedge clk) disable iff (reset)
        !(reply && recover)
    ) else $error("reply and recover both high");

    a_demod_idle: assert property (
        @(posedge clk) disable iff (reset)
        (state == xpdr_pkg::IDLE) |-> !demod_enable
    ) else $error("demodulator enabled while idle");

endmodule

/* src/mode_s_transponder.sv */
`timescale 1ns/1ps

module mode_s_transponder (
    input  logic               clk,
    input  logic               reset,
    input  logic               video,
    input  logic               sync_rev,
    input  logic               bit_valid,
    input  logic               bit_data,
    input  logic               cfg_write,
    input  xpdr_pkg::cfg_sel_t cfg_sel,
    input  logic [31:0]        cfg_wdata,
    output logic               demod_enable,
    output logic               atcrbs_suppressed,
    output logic               reply,
    output logic               recover
);

    logic                 preamble_ok;
    logic                 capture_start;
    logic                 frame_done;
    xpdr_pkg::uf_t        uf;
    xpdr_pkg::icao_addr_t ap_field;
    xpdr_pkg::icao_addr_t own_address;
    logic                 address_assigned;
    xpdr_pkg::uf_mask_t   uf_enable;

    xpdr_config u_config (
        .clk              (clk),
        .reset            (reset),
        .cfg_write        (cfg_write),
        .cfg_sel          (cfg_sel),
        .cfg_wdata        (cfg_wdata),
        .own_address      (own_address),
        .address_assigned (address_assigned),
        .uf_enable        (uf_enable)
    );

    pulse_qualifier u_qualifier (
        .clk         (clk),
        .reset       (reset),
        .video       (video),
        .preamble_ok (preamble_ok)
    );

    uplink_capture u_capture (
        .clk           (clk),
        .reset         (reset),
        .capture_start (capture_start),
        .bit_valid     (bit_valid),
        .bit_data      (bit_data),
        .frame_done    (frame_done),
        .uf            (uf),
        .ap_field      (ap_field)
    );

    interrogation_ctrl u_ctrl (
        .clk               (clk),
        .reset             (reset),
        .preamble_ok       (preamble_ok),
        .sync_rev          (sync_rev),
        .frame_done        (frame_done),
        .uf                (uf),
        .ap_field          (ap_field),
        .own_address       (own_address),
        .address_assigned  (address_assigned),
        .uf_enable         (uf_enable),
        .capture_start     (capture_start),
        .demod_enable      (demod_enable),
        .atcrbs_suppressed (atcrbs_suppressed),
        .reply             (reply),
        .recover           (recover)
    );

endmodule

/* tb/tb_mode_s_transponder.sv */
`timescale 1ns/1ps

module tb_mode_s_transponder;

    logic                 clk;
    logic                 reset;
    logic                 video;
    logic                 sync_rev;
    logic                 bit_valid;
    logic                 bit_data;
    logic                 cfg_write;
    xpdr_pkg::cfg_sel_t   cfg_sel;
    logic [31:0]          cfg_wdata;
    logic                 demod_enable;
    logic                 atcrbs_suppressed;
    logic                 reply;
    logic                 recover;

    xpdr_pkg::icao_addr_t model_own_addr;  // reference copy of the config registers
    logic                 model_assigned;
    xpdr_pkg::uf_mask_t   model_mask;
    logic [31:0]          rng_state;
    logic                 expect_quiet;    // no output may go high
    logic                 valid_p2_mark;   // P2 edge of a good preamble
    logic                 last_bit_mark;   // 56th bit_valid
    logic                 expect_reply;
    logic                 nosync_pending;  // preamble sent with no sync
    int                   nosync_age;
    int                   cycle_count;

    mode_s_transponder dut0 (
        .clk (clk), .reset (reset), .video (video), .sync_rev (sync_rev),
        .bit_valid (bit_valid), .bit_data (bit_data), .cfg_write (cfg_write),
        .cfg_sel (cfg_sel), .cfg_wdata (cfg_wdata), .demod_enable (demod_enable),
        .atcrbs_suppressed (atcrbs_suppressed), .reply (reply), .recover (recover)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        nosync_age  <= nosync_pending ? nosync_age + 1 : 0;
        if (cycle_count >= 6000) begin  // about 12 transactions of 400 cycles plus margin
            stop_with_failure("timeout: the run did not finish within 6000 cycles");
        end
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // uf enabled, and own address or the all-call pair
    function automatic logic expected_reply(input xpdr_pkg::uf_t f_uf,
                                            input xpdr_pkg::icao_addr_t f_ap);
        logic addr_match;
        addr_match = (model_assigned && (f_ap == model_own_addr)) ||
                     ((f_uf == 5'd11) && (f_ap == 24'hff_ffff));
        return model_mask[f_uf] && addr_match;
    endfunction

    task automatic write_config(input xpdr_pkg::cfg_sel_t sel, input logic [31:0] data);
        @(negedge clk);
        cfg_write = 1'b1;
        cfg_sel   = sel;
        cfg_wdata = data;
        @(negedge clk);
        cfg_write = 1'b0;
        if (sel == xpdr_pkg::CFG_OWN_ADDR) begin
            model_own_addr = data[23:0];
        end else if (sel == xpdr_pkg::CFG_ADDR_ASSIGNED) begin
            model_assigned = data[0];
        end else begin
            model_mask = data;
        end
    endtask

    task automatic send_preamble(input int p1_width, input int spacing,
                                 input logic good, input logic no_sync);
        @(negedge clk);
        video = 1'b1;
        repeat (p1_width) @(negedge clk);
        video = 1'b0;
        repeat (spacing - p1_width) @(negedge clk);
        video          = 1'b1;  // P2 leading edge
        valid_p2_mark  = good;
        nosync_pending = no_sync;
        @(negedge clk);
        valid_p2_mark = 1'b0;
        repeat (19) @(negedge clk);  // P2 is 20 cycles wide
        video = 1'b0;
    endtask

    task automatic send_sync(input int delay);
        repeat (delay) @(negedge clk);
        sync_rev = 1'b1;
        @(negedge clk);
        sync_rev = 1'b0;
    endtask

    task automatic send_frame(input logic [55:0] frame);
        int gap;
        for (int i = 55; i >= 0; i--) begin
            rng_state = xorshift32(rng_state);
            gap = int'(rng_state % 32'd3);  // 0 to 2 idle cycles
            repeat (gap) @(negedge clk);
            bit_valid     = 1'b1;
            bit_data      = frame[i];
            last_bit_mark = (i == 0);
            @(negedge clk);
            bit_valid     = 1'b0;
            last_bit_mark = 1'b0;
        end
    endtask

    task automatic wait_outcome();
        while (!(reply || recover)) begin
            @(negedge clk);
        end
        @(negedge clk);
        nosync_pending = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    task automatic run_frame(input xpdr_pkg::uf_t f_uf, input xpdr_pkg::icao_addr_t f_ap);
        logic [55:0] frame;
        rng_state    = xorshift32(rng_state);
        frame        = {f_uf, rng_state[26:0], f_ap};  // random middle bits
        expect_reply = expected_reply(f_uf, f_ap);
        send_preamble(20, 50, 1'b1, 1'b0);
        send_sync(10);
        send_frame(frame);
        wait_outcome();
    endtask

    task automatic check_rejected(input int p1_width, input int spacing);
        expect_quiet = 1'b1;
        send_preamble(p1_width, spacing, 1'b0, 1'b0);
        repeat (200) @(negedge clk);
        expect_quiet = 1'b0;
    endtask

    a_quiet: assert property (@(posedge clk) disable iff (reset)
        expect_quiet |-> !(reply || recover || demod_enable || atcrbs_suppressed)
    ) else stop_with_failure($sformatf("[FAIL] reply=0x%h recover=0x%h demod_enable=0x%h %s",
        reply, recover, demod_enable, $sformatf("atcrbs_suppressed=0x%h expected 0x0",
        atcrbs_suppressed)));

    a_levels_rise: assert property (@(posedge clk) disable iff (reset)
        $past(valid_p2_mark, 2) |-> (atcrbs_suppressed && demod_enable)
    ) else stop_with_failure($sformatf("[FAIL] atcrbs_suppressed=0x%h demod_enable=0x%h %s",
        atcrbs_suppressed, demod_enable, "expected 0x1 one cycle after P2"));

    a_levels_not_early: assert property (@(posedge clk) disable iff (reset)
        $past(valid_p2_mark) |-> !(atcrbs_suppressed || demod_enable)
    ) else stop_with_failure("suppression started before the P2 edge was qualified");

    a_outcome_value: assert property (@(posedge clk) disable iff (reset)
        $past(last_bit_mark, 3) |-> (reply == expect_reply) && (recover == !expect_reply)
    ) else stop_with_failure($sformatf("[FAIL] reply=0x%h recover=0x%h expected reply=0x%h",
        reply, recover, expect_reply));

    // a missing sync may only end in recover
    a_outcome_allowed: assert property (@(posedge clk) disable iff (reset)
        (reply || recover) |-> ($past(last_bit_mark, 3) || (nosync_pending && recover))
    ) else stop_with_failure("an outcome pulse came at a time when none was due");

    // levels still high the cycle before, low with the pulse
    a_levels_fall: assert property (@(posedge clk) disable iff (reset)
        (reply || recover) |-> !(demod_enable || atcrbs_suppressed) &&
            $past(demod_enable && atcrbs_suppressed)
    ) else stop_with_failure("demod_enable or atcrbs_suppressed did not fall with the outcome");

    a_sync_window: assert property (@(posedge clk) disable iff (reset)
        (nosync_pending && !recover) |-> (nosync_age <= xpdr_pkg::SYNC_WINDOW + 2)
    ) else stop_with_failure("no recover pulse within the sync window after the preamble");

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        video          = 1'b0;
        sync_rev       = 1'b0;
        bit_valid      = 1'b0;
        bit_data       = 1'b0;
        cfg_write      = 1'b0;
        cfg_sel        = xpdr_pkg::CFG_OWN_ADDR;
        cfg_wdata      = '0;
        model_own_addr = '0;
        model_assigned = 1'b0;
        model_mask     = 32'h0030_0830;  // uf 4, 5, 11, 20, 21
        rng_state      = 32'hfa31_e60f;
        expect_quiet   = 1'b1;
        valid_p2_mark  = 1'b0;
        last_bit_mark  = 1'b0;
        expect_reply   = 1'b0;
        nosync_pending = 1'b0;
        cycle_count    = 0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        repeat (50) @(negedge clk);  // idle line after reset
        expect_quiet = 1'b0;

        run_frame(5'd11, 24'hff_ffff);  // all-call, no address assigned yet
        write_config(xpdr_pkg::CFG_OWN_ADDR, 32'h0048_a3c5);
        write_config(xpdr_pkg::CFG_ADDR_ASSIGNED, 32'h0000_0001);
        run_frame(5'd4, 24'h48_a3c5);
        run_frame(5'd4, 24'h48_a3c4);
        run_frame(5'd16, 24'h48_a3c5);  // uf 16 not enabled
        write_config(xpdr_pkg::CFG_UF_MASK, model_mask & ~32'h0000_0010);
        run_frame(5'd4, 24'h48_a3c5);
        run_frame(5'd5, 24'h48_a3c5);

        check_rejected(12, 50);
        check_rejected(28, 50);
        check_rejected(20, 30);
        check_rejected(20, 60);

        send_preamble(20, 50, 1'b1, 1'b1);  // sync never sent
        wait_outcome();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* flist.f */
src/xpdr_pkg.sv
src/xpdr_config.sv
src/pulse_qualifier.sv
src/uplink_capture.sv
src/interrogation_ctrl.sv
src/mode_s_transponder.sv
tb/tb_mode_s_transponder.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the Mode S uplink testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f flist.f \
        --top-module tb_mode_s_transponder -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_mode_s_transponder > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if ! grep -qx "Simulation PASSED" sim.log; then
    echo "pass line not found in sim.log"
    exit 1
fi
exit 0
